// File: src/axil_ram_consts.svh
// 32-bit data only, byte address width sets depth, low 2 address bits are dropped
`ifndef AXIL_RAM_CONSTS_SVH
`define AXIL_RAM_CONSTS_SVH

// byte address width on the AXI side
`define AXIL_ADDR_W 12

// data bus, fixed at one 32-bit word
`define AXIL_DATA_W 32

// one strobe bit per byte lane
`define AXIL_STRB_W (`AXIL_DATA_W / 8)

// words of storage, byte offset bits removed
`define AXIL_DEPTH (1 << (`AXIL_ADDR_W - 2))

// only response code ever returned
`define AXIL_RESP_OKAY 2'b00

`endif

// File: src/axil_ram_pkg.sv
// payload types for the ram pipeline, needs axil_ram_consts.svh, no error or prot fields
`include "axil_ram_consts.svh"

package axil_ram_pkg;

    // single bit op, shared by request and response
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    // one memory access, word addressed
    typedef struct packed {
        mem_op_e                           op;
        logic [$clog2(`AXIL_DEPTH)-1:0]    addr;   // word index
        logic [`AXIL_DATA_W-1:0]           wdata;
        logic [`AXIL_STRB_W-1:0]           strb;   // zero for reads
    } mem_req_t;

    // result of one access
    typedef struct packed {
        mem_op_e                 op;     // picks B or R channel
        logic [`AXIL_DATA_W-1:0] rdata;  // only meaningful on reads
    } mem_rsp_t;

endpackage

// File: src/mem_req_if.sv
// one request link with valid/ready, payload must hold while valid is high and ready low
`timescale 1ns/1ps

interface mem_req_if;

    logic                   valid;
    logic                   ready;
    axil_ram_pkg::mem_req_t req;

    // producer side
    modport src (
        output valid,
        output req,
        input  ready
    );

    // consumer side
    modport dst (
        input  valid,
        input  req,
        output ready
    );

endinterface

// File: src/pipe_skid_buf.sv
// two-entry skid buffer, ready is registered so it lags one cycle and is low in reset
`timescale 1ns/1ps

module pipe_skid_buf #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  payload_t in_data_i,
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output payload_t out_data_o
);

    logic     out_valid_q;
    logic     skid_valid_q;
    logic     skid_valid_d;
    logic     ready_q;
    logic     in_fire;
    logic     out_load;        // output slot free or draining this cycle
    payload_t out_data_q;
    payload_t skid_data_q;

    assign in_fire  = in_valid_i && ready_q;
    assign out_load = !out_valid_q || out_ready_i;

    always_comb begin
        skid_valid_d = skid_valid_q;
        if (out_load) begin
            skid_valid_d = 1'b0;            // skid entry moves forward
        end else if (in_fire) begin
            skid_valid_d = 1'b1;            // output stalled, park input
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_valid_q  <= 1'b0;
            skid_valid_q <= 1'b0;
            ready_q      <= 1'b0;
        end else begin
            skid_valid_q <= skid_valid_d;
            ready_q      <= !skid_valid_d;  // free entry next cycle
            if (out_load) begin
                out_valid_q <= skid_valid_q || in_fire;
            end
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (out_load) begin
            out_data_q <= skid_valid_q ? skid_data_q : in_data_i;
        end else if (in_fire) begin
            skid_data_q <= in_data_i;
        end
    end

    assign in_ready_o  = ready_q;
    assign out_valid_o = out_valid_q;
    assign out_data_o  = out_data_q;

endmodule

// File: src/axil_req_arbiter.sv
// aw and w accepted only together, writes beat reads, one request per cycle, no prot
`timescale 1ns/1ps
`include "axil_ram_consts.svh"

module axil_req_arbiter (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    s_awvalid_i,
    output logic                    s_awready_o,
    input  logic [`AXIL_ADDR_W-1:0] s_awaddr_i,
    input  logic                    s_wvalid_i,
    output logic                    s_wready_o,
    input  logic [`AXIL_DATA_W-1:0] s_wdata_i,
    input  logic [`AXIL_STRB_W-1:0] s_wstrb_i,
    input  logic                    s_arvalid_i,
    output logic                    s_arready_o,
    input  logic [`AXIL_ADDR_W-1:0] s_araddr_i,
    mem_req_if.src                  req_o
);

    logic wr_pend;      // complete write waiting
    logic grant_wr;
    logic grant_rd;
    logic hold_q;       // last cycle offered but not taken
    logic hold_wr_q;    // which side was offered

    assign wr_pend = s_awvalid_i && s_wvalid_i;

    // a stalled offer keeps its side, so the payload cannot switch under it
    always_comb begin
        if (hold_q) begin
            grant_wr = hold_wr_q;
            grant_rd = !hold_wr_q;
        end else begin
            grant_wr = wr_pend;
            grant_rd = !wr_pend && s_arvalid_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hold_q    <= 1'b0;
            hold_wr_q <= 1'b0;
        end else begin
            hold_q    <= req_o.valid && !req_o.ready;
            hold_wr_q <= grant_wr;
        end
    end

    assign req_o.valid = grant_wr || grant_rd;

    // aw and w handshake in the same cycle
    assign s_awready_o = grant_wr && req_o.ready;
    assign s_wready_o  = grant_wr && req_o.ready;
    assign s_arready_o = grant_rd && req_o.ready;

    // byte address to word index, low two bits dropped
    always_comb begin
        req_o.req.op    = grant_wr ? axil_ram_pkg::MEM_WRITE : axil_ram_pkg::MEM_READ;
        req_o.req.addr  = grant_wr ? s_awaddr_i[`AXIL_ADDR_W-1:2]
                                   : s_araddr_i[`AXIL_ADDR_W-1:2];
        req_o.req.wdata = s_wdata_i;
        req_o.req.strb  = grant_wr ? s_wstrb_i : '0;  // reads never touch lanes
    end

endmodule

// File: src/byte_ram.sv
// single-port ram, contents unknown after power-up, one result slot, read-first
`timescale 1ns/1ps
`include "axil_ram_consts.svh"

module byte_ram (
    input  logic                   clk,
    input  logic                   rst_n_i,
    mem_req_if.dst                 req_i,
    output logic                   rsp_valid_o,
    input  logic                   rsp_ready_i,
    output axil_ram_pkg::mem_rsp_t rsp_o
);

    logic [`AXIL_DATA_W-1:0] mem_q [`AXIL_DEPTH];  // word array
    logic                    rsp_valid_q;
    axil_ram_pkg::mem_rsp_t  rsp_q;
    logic                    req_fire;

    // slot empty or emptying now
    assign req_i.ready = !rsp_valid_q || rsp_ready_i;
    assign req_fire    = req_i.valid && req_i.ready;

    // byte-lane writes commit at the transfer edge
    always_ff @(posedge clk) begin
        if (req_fire && req_i.req.op == axil_ram_pkg::MEM_WRITE) begin
            for (int i = 0; i < `AXIL_STRB_W; i++) begin
                if (req_i.req.strb[i]) begin
                    mem_q[req_i.req.addr][i*8 +: 8] <= req_i.req.wdata[i*8 +: 8];
                end
            end
        end
    end

    // registered result, held while the next stage stalls
    always_ff @(posedge clk) begin
        if (req_fire) begin
            rsp_q.op    <= req_i.req.op;
            rsp_q.rdata <= mem_q[req_i.req.addr];  // old word on writes, ignored
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else if (req_i.ready) begin
            rsp_valid_q <= req_i.valid;  // writes also produce a result
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = rsp_q;

endmodule

// File: src/axil_resp_stage.sv
// results leave in arrival order, a stalled B head also blocks R and vice versa, always OKAY
`timescale 1ns/1ps
`include "axil_ram_consts.svh"

module axil_resp_stage (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    rsp_valid_i,
    output logic                    rsp_ready_o,
    input  axil_ram_pkg::mem_rsp_t  rsp_i,
    output logic                    s_bvalid_o,
    input  logic                    s_bready_i,
    output logic [1:0]              s_bresp_o,
    output logic                    s_rvalid_o,
    input  logic                    s_rready_i,
    output logic [`AXIL_DATA_W-1:0] s_rdata_o,
    output logic [1:0]              s_rresp_o
);

    logic                   head_valid;
    logic                   head_ready;
    logic                   head_is_wr;
    axil_ram_pkg::mem_rsp_t head;

    pipe_skid_buf #(
        .payload_t (axil_ram_pkg::mem_rsp_t)
    ) u_rsp_buf (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (rsp_valid_i),
        .in_ready_o  (rsp_ready_o),
        .in_data_i   (rsp_i),
        .out_valid_o (head_valid),
        .out_ready_i (head_ready),
        .out_data_o  (head)
    );

    assign head_is_wr = (head.op == axil_ram_pkg::MEM_WRITE);

    // steer head by op
    assign s_bvalid_o = head_valid && head_is_wr;
    assign s_rvalid_o = head_valid && !head_is_wr;
    assign head_ready = head_is_wr ? s_bready_i : s_rready_i;  // ready of selected channel

    assign s_rdata_o = head.rdata;
    assign s_bresp_o = `AXIL_RESP_OKAY;
    assign s_rresp_o = `AXIL_RESP_OKAY;

endmodule

// File: src/axil_ram_top.sv
// axi4-lite ram slave, in-order responses, no error or prot support, 3 cycle best-case latency
`timescale 1ns/1ps
`include "axil_ram_consts.svh"

module axil_ram_top (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    s_awvalid_i,
    output logic                    s_awready_o,
    input  logic [`AXIL_ADDR_W-1:0] s_awaddr_i,
    input  logic                    s_wvalid_i,
    output logic                    s_wready_o,
    input  logic [`AXIL_DATA_W-1:0] s_wdata_i,
    input  logic [`AXIL_STRB_W-1:0] s_wstrb_i,
    output logic                    s_bvalid_o,
    input  logic                    s_bready_i,
    output logic [1:0]              s_bresp_o,
    input  logic                    s_arvalid_i,
    output logic                    s_arready_o,
    input  logic [`AXIL_ADDR_W-1:0] s_araddr_i,
    output logic                    s_rvalid_o,
    input  logic                    s_rready_i,
    output logic [`AXIL_DATA_W-1:0] s_rdata_o,
    output logic [1:0]              s_rresp_o
);

    mem_req_if req_in ();   // arbiter to request buffer
    mem_req_if req_reg ();  // request buffer to ram

    logic                   rsp_valid;
    logic                   rsp_ready;
    axil_ram_pkg::mem_rsp_t rsp;

    axil_req_arbiter u_arb (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .s_awvalid_i (s_awvalid_i),
        .s_awready_o (s_awready_o),
        .s_awaddr_i  (s_awaddr_i),
        .s_wvalid_i  (s_wvalid_i),
        .s_wready_o  (s_wready_o),
        .s_wdata_i   (s_wdata_i),
        .s_wstrb_i   (s_wstrb_i),
        .s_arvalid_i (s_arvalid_i),
        .s_arready_o (s_arready_o),
        .s_araddr_i  (s_araddr_i),
        .req_o       (req_in.src)
    );

    // stage 2, request register
    pipe_skid_buf #(
        .payload_t (axil_ram_pkg::mem_req_t)
    ) u_req_buf (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (req_in.valid),
        .in_ready_o  (req_in.ready),
        .in_data_i   (req_in.req),
        .out_valid_o (req_reg.valid),
        .out_ready_i (req_reg.ready),
        .out_data_o  (req_reg.req)
    );

    byte_ram u_ram (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_i       (req_reg.dst),
        .rsp_valid_o (rsp_valid),
        .rsp_ready_i (rsp_ready),
        .rsp_o       (rsp)
    );

    axil_resp_stage u_rsp (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .rsp_valid_i (rsp_valid),
        .rsp_ready_o (rsp_ready),
        .rsp_i       (rsp),
        .s_bvalid_o  (s_bvalid_o),
        .s_bready_i  (s_bready_i),
        .s_bresp_o   (s_bresp_o),
        .s_rvalid_o  (s_rvalid_o),
        .s_rready_i  (s_rready_i),
        .s_rdata_o   (s_rdata_o),
        .s_rresp_o   (s_rresp_o)
    );

endmodule

// File: testbench/axil_ram_checker.sv
// byte model starts at zero so every word must be written before it is read, single order queue
`timescale 1ns/1ps
`include "axil_ram_consts.svh"

module axil_ram_checker (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    s_awvalid_i,
    input  logic                    s_awready_i,
    input  logic [`AXIL_ADDR_W-1:0] s_awaddr_i,
    input  logic                    s_wvalid_i,
    input  logic                    s_wready_i,
    input  logic [`AXIL_DATA_W-1:0] s_wdata_i,
    input  logic [`AXIL_STRB_W-1:0] s_wstrb_i,
    input  logic                    s_bvalid_i,
    input  logic                    s_bready_i,
    input  logic [1:0]              s_bresp_i,
    input  logic                    s_arvalid_i,
    input  logic                    s_arready_i,
    input  logic [`AXIL_ADDR_W-1:0] s_araddr_i,
    input  logic                    s_rvalid_i,
    input  logic                    s_rready_i,
    input  logic [`AXIL_DATA_W-1:0] s_rdata_i,
    input  logic [1:0]              s_rresp_i,
    input  logic [`AXIL_DATA_W-1:0] exp_data_i,  // read value the pattern line claims
    input  logic [15:0]             test_idx_i,  // pattern line being driven
    output int                      req_cnt_o,
    output int                      rsp_cnt_o,
    output int                      err_cnt_o
);

    // one accepted request, in acceptance order
    typedef struct packed {
        logic                    is_wr;
        logic [15:0]             idx;
        logic [`AXIL_ADDR_W-1:0] addr;
        logic [`AXIL_DATA_W-1:0] data;  // model word, reads only
    } expect_t;

    logic [7:0] model [1 << `AXIL_ADDR_W];  // byte addressed copy of the ram
    expect_t    order_q [$];
    logic       prev_rst_n_q = 1'b0;         // reset level at the last edge
    int         req_cnt = 0;
    int         rsp_cnt = 0;
    int         err_cnt = 0;

    assign req_cnt_o = req_cnt;
    assign rsp_cnt_o = rsp_cnt;
    assign err_cnt_o = err_cnt;

    // word view of the model, low address bits ignored
    function automatic logic [`AXIL_DATA_W-1:0] model_word(input logic [`AXIL_ADDR_W-1:0] addr);
        logic [`AXIL_DATA_W-1:0] word;
        for (int i = 0; i < `AXIL_STRB_W; i++) begin
            word[i*8 +: 8] = model[{addr[`AXIL_ADDR_W-1:2], 2'(i)}];
        end
        return word;
    endfunction

    task automatic value_error(input logic [15:0] idx, input string name,
                               input logic [31:0] got, input logic [31:0] exp);
        err_cnt++;
        $display("FAIL t=%0t test %0d %s got 0x%08h expected 0x%08h", $time, idx, name, got, exp);
    endtask

    task automatic plain_error(input string msg);
        err_cnt++;
        $display("ERROR t=%0t %s", $time, msg);
    endtask

    // pop the oldest request and compare, one line per finished response
    task automatic take_response(input logic is_wr, input logic [31:0] data,
                                 input logic [1:0] resp);
        expect_t exp;
        int      errs_before;
        errs_before = err_cnt;
        rsp_cnt++;
        if (order_q.size() == 0) begin
            plain_error("a response arrived with no request outstanding");
        end else begin
            exp = order_q.pop_front();
            if (exp.is_wr != is_wr) begin
                plain_error($sformatf("test %0d response came on the wrong channel", exp.idx));
            end else if (is_wr) begin
                if (resp != `AXIL_RESP_OKAY)
                    value_error(exp.idx, "s_bresp_o", {30'b0, resp}, {30'b0, `AXIL_RESP_OKAY});
            end else begin
                if (resp != `AXIL_RESP_OKAY)
                    value_error(exp.idx, "s_rresp_o", {30'b0, resp}, {30'b0, `AXIL_RESP_OKAY});
                if (data !== exp.data)
                    value_error(exp.idx, "s_rdata_o", data, exp.data);
            end
            if (err_cnt == errs_before && is_wr)
                $display("test %0d write 0x%03h ok", exp.idx, exp.addr);
            else if (err_cnt == errs_before)
                $display("test %0d read 0x%03h data 0x%08h ok", exp.idx, exp.addr, data);
        end
    endtask

    // pre-edge values, every handshake seen here
    always @(posedge clk) begin
        logic [`AXIL_DATA_W-1:0] word;
        expect_t                 entry;
        if (!rst_n_i || !prev_rst_n_q) begin  // in reset or first cycle out of it
            if (s_awready_i || s_wready_i || s_arready_i || s_bvalid_i || s_rvalid_i)
                plain_error("a ready or valid output was high during or right after reset");
        end
        prev_rst_n_q <= rst_n_i;

        if (s_awvalid_i && s_awready_i) begin
            if (!(s_wvalid_i && s_wready_i))
                plain_error("AW was accepted without W in the same cycle");
            for (int i = 0; i < `AXIL_STRB_W; i++) begin
                if (s_wstrb_i[i])
                    model[{s_awaddr_i[`AXIL_ADDR_W-1:2], 2'(i)}] = s_wdata_i[i*8 +: 8];
            end
            entry.is_wr = 1'b1;
            entry.idx   = test_idx_i;
            entry.addr  = s_awaddr_i;
            entry.data  = '0;
            order_q.push_back(entry);
            req_cnt++;
        end else if (s_wvalid_i && s_wready_i) begin
            plain_error("W was accepted without AW");
        end

        if (s_arvalid_i && s_arready_i) begin
            if (s_awvalid_i && s_wvalid_i)  // write must win
                plain_error("a read was accepted while a complete write was waiting");
            word = model_word(s_araddr_i);
            if (exp_data_i !== word)        // pattern file disagrees with model
                value_error(test_idx_i, "pattern expected data", exp_data_i, word);
            entry.is_wr = 1'b0;
            entry.idx   = test_idx_i;
            entry.addr  = s_araddr_i;
            entry.data  = word;
            order_q.push_back(entry);
            req_cnt++;
        end

        if (s_bvalid_i && s_bready_i) take_response(1'b1, '0, s_bresp_i);
        if (s_rvalid_i && s_rready_i) take_response(1'b0, s_rdata_i, s_rresp_i);
    end

endmodule

// File: testbench/tb_axil_ram.sv
// run from the project root, patterns from testbench/axil_ram_patterns.hex ending at op f
`timescale 1ns/1ps
`include "axil_ram_consts.svh"

module tb_axil_ram;

    localparam int MAX_PAT = 64;
    localparam int PAT_W   = 5;  // words per line: op addr wdata strb expected

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    awvalid;
    logic                    wvalid;
    logic                    arvalid;
    logic                    bready = 1'b0;
    logic                    rready = 1'b0;
    logic [`AXIL_ADDR_W-1:0] awaddr;
    logic [`AXIL_ADDR_W-1:0] araddr;
    logic [`AXIL_DATA_W-1:0] wdata;
    logic [`AXIL_STRB_W-1:0] wstrb;
    logic                    awready;
    logic                    wready;
    logic                    arready;
    logic                    bvalid;
    logic                    rvalid;
    logic [1:0]              bresp;
    logic [1:0]              rresp;
    logic [`AXIL_DATA_W-1:0] rdata;

    logic [31:0] pat_mem [MAX_PAT*PAT_W];
    logic [31:0] exp_data;
    logic [15:0] test_idx;
    logic        bp_on;             // random bready/rready
    logic        wr_left;           // write handshake still owed
    logic        rd_left;
    int          num_pat = 0;
    int          num_req = 0;
    int          cycle_cnt = 0;
    int          cycle_limit = 100;
    int          req_cnt;
    int          rsp_cnt;
    int          err_cnt;
    integer      seed = 32'hdc42;

    always #5 clk = ~clk;  // 10 ns period

    axil_ram_top u_dut (
        .clk (clk), .rst_n_i (rst_n),
        .s_awvalid_i (awvalid), .s_awready_o (awready), .s_awaddr_i (awaddr),
        .s_wvalid_i (wvalid), .s_wready_o (wready), .s_wdata_i (wdata), .s_wstrb_i (wstrb),
        .s_bvalid_o (bvalid), .s_bready_i (bready), .s_bresp_o (bresp),
        .s_arvalid_i (arvalid), .s_arready_o (arready), .s_araddr_i (araddr),
        .s_rvalid_o (rvalid), .s_rready_i (rready), .s_rdata_o (rdata), .s_rresp_o (rresp)
    );

    axil_ram_checker u_chk (
        .clk (clk), .rst_n_i (rst_n),
        .s_awvalid_i (awvalid), .s_awready_i (awready), .s_awaddr_i (awaddr),
        .s_wvalid_i (wvalid), .s_wready_i (wready), .s_wdata_i (wdata), .s_wstrb_i (wstrb),
        .s_bvalid_i (bvalid), .s_bready_i (bready), .s_bresp_i (bresp),
        .s_arvalid_i (arvalid), .s_arready_i (arready), .s_araddr_i (araddr),
        .s_rvalid_i (rvalid), .s_rready_i (rready), .s_rdata_i (rdata), .s_rresp_i (rresp),
        .exp_data_i (exp_data), .test_idx_i (test_idx),
        .req_cnt_o (req_cnt), .rsp_cnt_o (rsp_cnt), .err_cnt_o (err_cnt)
    );

    // put one pattern line on the bus, op 2 raises AW, W and AR together
    task automatic present(input int k);
        logic [31:0] op;
        op      = pat_mem[k*PAT_W];
        wr_left = (op == 32'd1) || (op == 32'd2);
        rd_left = (op == 32'd0) || (op == 32'd2);
        awvalid  <= wr_left;
        wvalid   <= wr_left;
        arvalid  <= rd_left;
        if (wr_left) begin  // idle channel keeps its last address
            awaddr <= pat_mem[k*PAT_W+1][`AXIL_ADDR_W-1:0];
            wdata  <= pat_mem[k*PAT_W+2];
            wstrb  <= pat_mem[k*PAT_W+3][`AXIL_STRB_W-1:0];
        end
        if (rd_left) begin
            araddr <= pat_mem[k*PAT_W+1][`AXIL_ADDR_W-1:0];
        end
        exp_data <= pat_mem[k*PAT_W+4];
        test_idx <= 16'(k);
    endtask

    // response readies, held high for the first half of the list
    always @(posedge clk) begin
        logic [31:0] rnd;
        rnd = $random(seed);
        if (bp_on) begin
            bready <= rnd[0];
            rready <= rnd[1];
        end else begin
            bready <= 1'b1;
            rready <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d of %0d responses seen",
                     cycle_cnt, rsp_cnt, num_req);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        int k;
        rst_n    <= 1'b0;
        awvalid  <= 1'b0;
        wvalid   <= 1'b0;
        arvalid  <= 1'b0;
        awaddr   <= '0;
        araddr   <= '0;
        wdata    <= '0;
        wstrb    <= '0;
        exp_data <= '0;
        test_idx <= '0;
        bp_on    <= 1'b0;
        wr_left  = 1'b0;
        rd_left  = 1'b0;
        $readmemh("testbench/axil_ram_patterns.hex", pat_mem);
        while (num_pat < MAX_PAT && pat_mem[num_pat*PAT_W] != 32'hf) begin
            num_req += (pat_mem[num_pat*PAT_W] == 32'd2) ? 2 : 1;
            num_pat++;
        end
        cycle_limit = 20 * num_pat + 100;

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;  // first line goes out with the reset release
        k = 0;
        if (num_pat > 0)
            present(0);
        else
            $display("no patterns were found in the pattern file");
        while (k < num_pat) begin
            @(posedge clk);
            if (wr_left && awvalid && awready) begin
                wr_left = 1'b0;
                awvalid <= 1'b0;
                wvalid  <= 1'b0;
            end
            if (rd_left && arvalid && arready) begin
                rd_left = 1'b0;
                arvalid <= 1'b0;
            end
            if (!wr_left && !rd_left) begin  // next line on the same edge
                k++;
                if (k >= num_pat / 2) bp_on <= 1'b1;
                if (k < num_pat) present(k);
            end
        end

        while (rsp_cnt < num_req) @(negedge clk);
        repeat (10) @(posedge clk);  // quiet period, catches stray responses
        @(negedge clk);
        $display("summary: %0d patterns, %0d requests, %0d responses, %0d errors",
                 num_pat, req_cnt, rsp_cnt, err_cnt);
        if (num_pat > 0 && err_cnt == 0 && req_cnt == num_req && rsp_cnt == num_req)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// File: testbench/axil_ram_patterns.hex
// op addr wdata strb expected, all hex
// op 0 read, 1 write, 2 write and read together, f ends the list
1 000 11223344 f 00000000
0 000 00000000 0 11223344
1 004 aabbccdd f 00000000
1 004 00000055 1 00000000
1 004 00990000 4 00000000
0 004 00000000 0 aa99cc55
1 008 cafef00d f 00000000
1 00c 01020304 f 00000000
0 008 00000000 0 cafef00d
0 00c 00000000 0 01020304
2 010 5a5a5a5a f 5a5a5a5a
1 013 0000ff00 2 00000000
0 012 00000000 0 5a5aff5a
// second half runs with random bready and rready
1 100 deadbeef f 00000000
1 104 0badf00d f 00000000
0 100 00000000 0 deadbeef
1 100 12000000 8 00000000
0 104 00000000 0 0badf00d
0 100 00000000 0 12adbeef
2 ffc 76543210 f 76543210
1 ffc 000000ab 1 00000000
0 ffc 00000000 0 765432ab
0 000 00000000 0 11223344
1 200 ffffffff f 00000000
1 200 00000000 6 00000000
0 200 00000000 0 ff0000ff
0 004 00000000 0 aa99cc55
f 000 00000000 0 00000000

// File: vlog.f
+incdir+src
src/axil_ram_pkg.sv
src/mem_req_if.sv
src/pipe_skid_buf.sv
src/axil_req_arbiter.sv
src/byte_ram.sv
src/axil_resp_stage.sv
src/axil_ram_top.sv
testbench/axil_ram_checker.sv
testbench/tb_axil_ram.sv

// File: Makefile
SRCS := $(shell grep -v '^+' vlog.f) src/axil_ram_consts.svh

all: check

obj_dir/Vtb_axil_ram: vlog.f $(SRCS) testbench/axil_ram_patterns.hex
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_axil_ram -f vlog.f

run: obj_dir/Vtb_axil_ram
	./obj_dir/Vtb_axil_ram | tee sim.log
	@! grep -q "Verification failed" sim.log

check: run
	@grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run check clean
